// ==== source/icache_pkg.sv ====
package icache_pkg;

    // Cache geometry
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;
    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;

    // Address field widths
    localparam int BOFF_W  = $clog2(WORD_W / 8);
    localparam int WOFF_W  = $clog2(BLOCK_WORDS);
    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int WAY_W   = $clog2(NUM_WAYS);
    localparam int TAG_W   = ADDR_W - INDEX_W - WOFF_W - BOFF_W;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [WOFF_W-1:0]  woff;
        logic [BOFF_W-1:0]  boff;
    } fetch_addr_t;

    // Word 0 sits in the low bits
    typedef logic [BLOCK_WORDS-1:0][WORD_W-1:0] cache_block_t;

    typedef struct packed {
        logic               we;
        logic [INDEX_W-1:0] index;
        logic [WAY_W-1:0]   way;
        logic [TAG_W-1:0]   tag;
        cache_block_t       data;
    } refill_wr_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        FILL = 2'd1,  // waiting on the critical word
        DONE = 2'd2   // critical word in, rest of block streaming
    } refill_state_e;

    typedef enum logic [1:0] {
        CTRL     = 2'd0,
        INVAL    = 2'd1,
        HIT_CNT  = 2'd2,
        MISS_CNT = 2'd3
    } cfg_addr_e;

    typedef struct packed {
        logic early_restart_en;
    } cfg_t;

endpackage

// ==== source/icache_store.sv ====
`timescale 1ns/1ps

module icache_store (
    input  logic                          Clk,
    input  logic                          rst_n,
    input  logic                          lookup,
    input  icache_pkg::fetch_addr_t       lookup_addr,
    input  icache_pkg::refill_wr_t        fill,
    input  logic                          inval,
    output logic                          hit,
    output logic [icache_pkg::WORD_W-1:0] hit_word,
    output logic [icache_pkg::WAY_W-1:0]  victim_way
);
    import icache_pkg::*;

    logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];
    cache_block_t        data_q  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [WAY_W-1:0]    rr_q    [NUM_SETS];

    logic [NUM_WAYS-1:0] way_hit;
    logic [WAY_W-1:0]    hit_way;
    logic                dup_tag;

    // Parallel tag compare across the addressed set
    always_comb begin
        way_hit = '0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[lookup_addr.index][w] && tag_q[lookup_addr.index][w] == lookup_addr.tag) begin
                way_hit[w] = 1'b1;
                hit_way    = WAY_W'(w);
            end
        end
    end

    assign hit      = lookup && (|way_hit);
    assign hit_word = data_q[lookup_addr.index][hit_way][lookup_addr.woff];

    // Lowest invalid way wins, round-robin otherwise
    always_comb begin
        victim_way = rr_q[lookup_addr.index];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[lookup_addr.index][w]) begin
                victim_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (inval) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill.we) begin
            valid_q[fill.index][fill.way] <= 1'b1;
            rr_q[fill.index]              <= rr_q[fill.index] + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fill.we) begin
            tag_q[fill.index][fill.way]  <= fill.tag;
            data_q[fill.index][fill.way] <= fill.data;
        end
    end

    always_comb begin
        dup_tag = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int a = 0; a < NUM_WAYS - 1; a++) begin
                for (int b = a + 1; b < NUM_WAYS; b++) begin
                    if (valid_q[s][a] && valid_q[s][b] && tag_q[s][a] == tag_q[s][b]) begin
                        dup_tag = 1'b1;
                    end
                end
            end
        end
    end

    // Refills only follow real misses, so a tag never lands twice in a set
    a_unique_tag: assert property (@(posedge Clk) disable iff (!rst_n) !dup_tag);

endmodule

// ==== source/icache_refill.sv ====
`timescale 1ns/1ps

module icache_refill (
    input  logic                          Clk,
    input  logic                          rst_n,
    input  logic                          read_en,
    input  logic                          redirect,
    input  icache_pkg::fetch_addr_t       read_address,
    input  logic                          hit,
    input  logic [icache_pkg::WORD_W-1:0] hit_word,
    input  logic [icache_pkg::WAY_W-1:0]  victim_way,
    input  icache_pkg::cfg_t              cfg,
    input  logic [icache_pkg::WORD_W-1:0] mem_data,
    input  logic                          mem_data_valid,
    output logic                          lookup,
    output icache_pkg::refill_wr_t        fill,
    output logic                          miss,
    output logic [icache_pkg::WORD_W-1:0] instruction,
    output logic                          ready,
    output logic                          busy,
    output logic [icache_pkg::ADDR_W-1:0] mem_address,
    output logic                          mem_req
);
    import icache_pkg::*;

    refill_state_e     state;
    fetch_addr_t       miss_addr;
    logic [WAY_W-1:0]  miss_way;
    logic [WOFF_W-1:0] word_cnt;
    logic [WOFF_W-1:0] rank;
    logic [WOFF_W-1:0] slot;
    logic              er_mode;
    logic              take;
    logic              last_beat;
    cache_block_t      blk_q;
    cache_block_t      blk_next;

    assign lookup = redirect || (read_en && !busy);
    assign miss   = lookup && !hit;

    // A beat in the redirect cycle belongs to the abandoned block
    assign take      = mem_req && mem_data_valid && !redirect;
    assign last_beat = (state == DONE) && (word_cnt == WOFF_W'(BLOCK_WORDS - 1));

    // Later words come in ascending order around the critical slot
    assign rank = word_cnt - 1'b1;

    always_comb begin
        if (state == FILL) begin
            slot = miss_addr.woff;
        end else if (rank < miss_addr.woff) begin
            slot = rank;
        end else begin
            slot = word_cnt;
        end
    end

    always_comb begin
        blk_next = blk_q;
        blk_next[slot] = mem_data;
    end

    always_comb begin
        fill.we    = take && last_beat;
        fill.index = miss_addr.index;
        fill.way   = miss_way;
        fill.tag   = miss_addr.tag;
        fill.data  = blk_next;
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            busy     <= 1'b0;
            mem_req  <= 1'b0;
            ready    <= 1'b0;
            word_cnt <= '0;
            er_mode  <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (lookup) begin
                if (hit) begin
                    ready   <= 1'b1;
                    state   <= IDLE;
                    busy    <= 1'b0;
                    mem_req <= 1'b0;
                end else begin
                    state    <= FILL;
                    busy     <= 1'b1;
                    // Aborting a refill needs one low cycle on the request
                    mem_req  <= !busy;
                    word_cnt <= '0;
                    er_mode  <= cfg.early_restart_en;
                end
            end else begin
                case (state)
                    FILL: begin
                        if (!mem_req) begin
                            mem_req <= 1'b1;
                        end else if (take) begin
                            ready    <= er_mode;
                            state    <= DONE;
                            word_cnt <= WOFF_W'(1);
                        end
                    end
                    DONE: begin
                        if (take) begin
                            word_cnt <= word_cnt + 1'b1;
                            if (last_beat) begin
                                state   <= IDLE;
                                busy    <= 1'b0;
                                mem_req <= 1'b0;
                                ready   <= !er_mode;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (miss) begin
            miss_addr   <= read_address;
            miss_way    <= victim_way;
            mem_address <= {read_address.tag, read_address.index, read_address.woff,
                            {BOFF_W{1'b0}}};
        end
        if (take) begin
            blk_q <= blk_next;
        end
        // Critical word is held for either restart mode
        if (lookup && hit) begin
            instruction <= hit_word;
        end else if (take && state == FILL) begin
            instruction <= mem_data;
        end
    end

    a_req_held: assert property (@(posedge Clk) disable iff (!rst_n)
        (state != IDLE) && mem_req && !redirect && !fill.we |=> mem_req);

    // After an early restart no further ready until the block is done
    a_one_ready: assert property (@(posedge Clk) disable iff (!rst_n || redirect)
        ready && busy |=> !ready until_with !busy);

endmodule

// ==== source/icache_cfg_regs.sv ====
`timescale 1ns/1ps

module icache_cfg_regs (
    input  logic                  Clk,
    input  logic                  rst_n,
    input  logic                  cfg_wr,
    input  icache_pkg::cfg_addr_e cfg_addr,
    input  logic [31:0]           cfg_wdata,
    input  logic                  hit,
    input  logic                  miss,
    input  logic                  busy,
    output logic [31:0]           cfg_rdata,
    output icache_pkg::cfg_t      cfg,
    output logic                  inval
);
    import icache_pkg::*;

    logic [31:0] hit_cnt;
    logic [31:0] miss_cnt;
    logic        ctrl_wr;

    assign ctrl_wr = cfg_wr && (cfg_addr == CTRL);

    // Invalidate is dropped while a refill is running
    assign inval = cfg_wr && (cfg_addr == INVAL) && !busy;

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.early_restart_en <= 1'b1;
            hit_cnt              <= '0;
            miss_cnt             <= '0;
        end else if (ctrl_wr) begin
            cfg.early_restart_en <= cfg_wdata[0];
            hit_cnt              <= '0;
            miss_cnt             <= '0;
        end else begin
            // Saturating counters
            if (hit && hit_cnt != '1) begin
                hit_cnt <= hit_cnt + 1'b1;
            end
            if (miss && miss_cnt != '1) begin
                miss_cnt <= miss_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            CTRL:     cfg_rdata = {31'd0, cfg.early_restart_en};
            HIT_CNT:  cfg_rdata = hit_cnt;
            MISS_CNT: cfg_rdata = miss_cnt;
            default:  cfg_rdata = '0;
        endcase
    end

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                          Clk,
    input  logic                          rst_n,
    input  logic                          read_en,
    input  icache_pkg::fetch_addr_t       read_address,
    input  logic                          redirect,
    output logic [icache_pkg::WORD_W-1:0] instruction,
    output logic                          ready,
    output logic                          busy,
    output logic [icache_pkg::ADDR_W-1:0] mem_address,
    output logic                          mem_req,
    input  logic [icache_pkg::WORD_W-1:0] mem_data,
    input  logic                          mem_data_valid,
    input  logic                          cfg_wr,
    input  icache_pkg::cfg_addr_e         cfg_addr,
    input  logic [31:0]                   cfg_wdata,
    output logic [31:0]                   cfg_rdata
);
    import icache_pkg::*;

    logic              lookup;
    logic              hit;
    logic [WORD_W-1:0] hit_word;
    logic [WAY_W-1:0]  victim_way;
    refill_wr_t        fill;
    logic              miss;
    logic              inval;
    cfg_t              cfg;

    icache_store u_store (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .lookup      (lookup),
        .lookup_addr (read_address),
        .fill        (fill),
        .inval       (inval),
        .hit         (hit),
        .hit_word    (hit_word),
        .victim_way  (victim_way)
    );

    icache_refill u_refill (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .read_en        (read_en),
        .redirect       (redirect),
        .read_address   (read_address),
        .hit            (hit),
        .hit_word       (hit_word),
        .victim_way     (victim_way),
        .cfg            (cfg),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid),
        .lookup         (lookup),
        .fill           (fill),
        .miss           (miss),
        .instruction    (instruction),
        .ready          (ready),
        .busy           (busy),
        .mem_address    (mem_address),
        .mem_req        (mem_req)
    );

    icache_cfg_regs u_cfg_regs (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .hit       (hit),
        .miss      (miss),
        .busy      (busy),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg),
        .inval     (inval)
    );

endmodule

// ==== tests/icache_mem_model.sv ====
`timescale 1ns/1ps

module icache_mem_model (
    input  logic        Clk,
    input  logic        rst_n,
    input  logic        mem_req,
    input  logic [31:0] mem_address,
    input  logic [2:0]  latency,
    output logic [31:0] mem_data,
    output logic        mem_data_valid
);

    logic        active;
    logic [2:0]  beat;
    logic [2:0]  wait_cnt;
    logic [31:0] base;

    // Critical word first, then ascending order without it
    function automatic logic [1:0] beat_word(input logic [1:0] crit, input logic [2:0] k);
        if (k == 0) begin
            return crit;
        end else if (k - 1 < crit) begin
            return 2'(k - 1);
        end else begin
            return 2'(k);
        end
    endfunction

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            active         <= 1'b0;
            beat           <= '0;
            wait_cnt       <= '0;
            base           <= '0;
            mem_data       <= '0;
            mem_data_valid <= 1'b0;
        end else begin
            mem_data_valid <= 1'b0;
            if (!mem_req) begin
                // Request dropped, abandon the block
                active <= 1'b0;
            end else if (!active) begin
                active   <= 1'b1;
                beat     <= '0;
                wait_cnt <= latency;
                base     <= mem_address;
            end else if (beat < 4) begin
                if (wait_cnt > 1) begin
                    wait_cnt <= wait_cnt - 1'b1;
                end else begin
                    mem_data       <= {base[31:4], beat_word(base[3:2], beat), 2'b00}
                                      ^ 32'hA5A5_0000;
                    mem_data_valid <= 1'b1;
                    beat           <= beat + 1'b1;
                    wait_cnt       <= latency;
                end
            end
        end
    end

endmodule

// ==== tests/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    // Fetches issued by the sequence below
    localparam int MAX_ACCESSES = 43;
    localparam int CYCLE_LIMIT  = 40 * MAX_ACCESSES + 200;

    logic        Clk;
    logic        rst_n;
    logic        read_en;
    fetch_addr_t read_address;
    logic        redirect;
    logic [31:0] instruction;
    logic        ready;
    logic        busy;
    logic [31:0] mem_address;
    logic        mem_req;
    logic [31:0] mem_data;
    logic        mem_data_valid;
    logic        cfg_wr;
    cfg_addr_e   cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;
    logic [2:0]  mem_lat;

    // Reference cache state
    logic [TAG_W-1:0]    ref_tag   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] ref_valid [NUM_SETS];
    int                  ref_rr    [NUM_SETS];
    int                  n_hit;
    int                  n_miss;
    bit                  er_on;
    int                  cycles;

    icache_top uut (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .read_en        (read_en),
        .read_address   (read_address),
        .redirect       (redirect),
        .instruction    (instruction),
        .ready          (ready),
        .busy           (busy),
        .mem_address    (mem_address),
        .mem_req        (mem_req),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid),
        .cfg_wr         (cfg_wr),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .cfg_rdata      (cfg_rdata)
    );

    icache_mem_model u_mem (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_address    (mem_address),
        .latency        (mem_lat),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid)
    );

    initial Clk = 1'b0;
    always #10 Clk = ~Clk;

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Test failed");
            $fatal(1, "Timeout: the run went past %0d cycles", CYCLE_LIMIT);
        end
    end

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int woff);
        fetch_addr_t f;
        f.tag   = TAG_W'(tag);
        f.index = INDEX_W'(set);
        f.woff  = WOFF_W'(woff);
        f.boff  = '0;
        return f;
    endfunction

    function automatic bit ref_hit(input fetch_addr_t a);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[a.index][w] && ref_tag[a.index][w] == a.tag) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic ref_fill(input fetch_addr_t a);
        int victim;
        victim = ref_rr[a.index];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!ref_valid[a.index][w]) begin
                victim = w;
            end
        end
        ref_tag[a.index][victim]   = a.tag;
        ref_valid[a.index][victim] = 1'b1;
        ref_rr[a.index]            = (ref_rr[a.index] + 1) % NUM_WAYS;
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // Follows one refill from the lookup cycle to busy falling
    task automatic finish_refill(input logic [31:0] a);
        int  t;
        int  beats;
        int  readies;
        int  first_v;
        int  last_v;
        int  rdy_cyc;
        bit  seen_req;
        t        = 0;
        beats    = 0;
        readies  = 0;
        first_v  = 0;
        last_v   = 0;
        rdy_cyc  = 0;
        seen_req = 1'b0;
        forever begin
            @(negedge Clk);
            t++;
            if (mem_req && !seen_req) begin
                seen_req = 1'b1;
                check("mem_req rise cycle", t, 1);
                check("mem_address", mem_address, {a[31:2], 2'b00});
            end
            if (ready) begin
                readies++;
                rdy_cyc = t;
                check("refill word", instruction, expected_word(a));
            end
            if (mem_data_valid) begin
                if (beats == 0) begin
                    first_v = t;
                end
                beats++;
                last_v = t;
            end
            if (!busy) begin
                break;
            end
        end
        check("ready count", readies, 1);
        check("beat count", beats, BLOCK_WORDS);
        check("busy end", t, last_v + 1);
        if (er_on) begin
            check("early restart ready", rdy_cyc, first_v + 1);
        end else begin
            check("late ready", rdy_cyc, last_v + 1);
        end
    endtask

    task automatic fetch(input logic [31:0] a);
        bit exp_hit;
        exp_hit = ref_hit(a);
        @(posedge Clk);
        read_en      <= 1'b1;
        read_address <= a;
        mem_lat      <= 3'($urandom_range(1, 5));
        @(posedge Clk);
        read_en <= 1'b0;
        @(negedge Clk);
        check("ready after lookup", ready, exp_hit);
        check("busy after lookup", busy, !exp_hit);
        check("mem_req after lookup", mem_req, !exp_hit);
        if (exp_hit) begin
            n_hit++;
            check("hit word", instruction, expected_word(a));
        end else begin
            n_miss++;
            finish_refill(a);
            ref_fill(a);
        end
    endtask

    task automatic write_reg(input cfg_addr_e addr, input logic [31:0] data);
        @(posedge Clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge Clk);
        cfg_wr <= 1'b0;
    endtask

    task automatic read_reg(input cfg_addr_e addr, input logic [31:0] exp);
        @(posedge Clk);
        cfg_addr <= addr;
        @(negedge Clk);
        check("register read", cfg_rdata, exp);
    endtask

    task automatic set_early_restart(input bit on);
        write_reg(CTRL, {31'd0, on});
        er_on  = on;
        n_hit  = 0;
        n_miss = 0;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pool [8];
        int          s;
        int          t0;
        void'($urandom(32'h22d6_88d5));
        rst_n        = 1'b0;
        read_en      = 1'b0;
        read_address = '0;
        redirect     = 1'b0;
        cfg_wr       = 1'b0;
        cfg_addr     = CTRL;
        cfg_wdata    = '0;
        mem_lat      = 3'd1;
        cycles       = 0;
        n_hit        = 0;
        n_miss       = 0;
        er_on        = 1'b1;
        for (int i = 0; i < NUM_SETS; i++) begin
            ref_valid[i] = '0;
            ref_rr[i]    = 0;
        end
        repeat (4) @(posedge Clk);
        rst_n <= 1'b1;
        @(negedge Clk);
        check("ready after reset", ready, 0);
        check("busy after reset", busy, 0);
        check("mem_req after reset", mem_req, 0);
        read_reg(CTRL, 32'd1);

        // Cold miss followed by hits on every word of the block
        set_early_restart(1'b0);
        a = make_addr(100, $urandom_range(0, 7), $urandom_range(0, 3));
        fetch(a);
        fetch(a);
        for (int w = 0; w < BLOCK_WORDS; w++) begin
            fetch({a[31:4], 2'(w), 2'b00});
        end

        // Five blocks into one set
        s  = $urandom_range(0, 7);
        t0 = 200;
        for (int i = 0; i < 5; i++) begin
            fetch(make_addr(t0 + i, s, $urandom_range(0, 3)));
        end
        for (int i = 0; i < 5; i++) begin
            fetch(make_addr(t0 + i, s, $urandom_range(0, 3)));
        end

        // Early restart with random traffic
        set_early_restart(1'b1);
        for (int i = 0; i < 8; i++) begin
            pool[i] = make_addr(300 + $urandom_range(0, 5), $urandom_range(0, 7), 0);
        end
        for (int i = 0; i < 20; i++) begin
            a = pool[$urandom_range(0, 7)];
            fetch({a[31:4], 2'($urandom_range(0, 3)), 2'b00});
        end

        // Redirect abandons a refill before any data
        a = make_addr(500, 1, 2);
        b = make_addr(501, 2, 3);
        @(posedge Clk);
        read_en      <= 1'b1;
        read_address <= a;
        mem_lat      <= 3'd5;
        @(posedge Clk);
        read_en <= 1'b0;
        n_miss++;
        @(negedge Clk);
        while (!mem_req) begin
            @(negedge Clk);
        end
        @(posedge Clk);
        redirect     <= 1'b1;
        read_address <= b;
        @(posedge Clk);
        redirect <= 1'b0;
        @(negedge Clk);
        check("mem_req after redirect", mem_req, 0);
        check("busy after redirect", busy, 1);
        n_miss++;
        finish_refill(b);
        ref_fill(b);
        fetch(a);
        fetch(b);

        // Invalidate and counters
        a = pool[0];
        fetch(a);
        fetch(a);
        write_reg(INVAL, 32'd0);
        for (int i = 0; i < NUM_SETS; i++) begin
            ref_valid[i] = '0;
        end
        fetch(a);
        read_reg(HIT_CNT, n_hit);
        read_reg(MISS_CNT, n_miss);

        $display("Test passed");
        $finish;
    end

endmodule

// ==== sources.f ====
source/icache_pkg.sv
source/icache_store.sv
source/icache_refill.sv
source/icache_cfg_regs.sv
source/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/icache_store.sv
  - source/icache_refill.sv
  - source/icache_cfg_regs.sv
  - source/icache_top.sv
  - target: test
    files:
      - tests/icache_mem_model.sv
      - tests/icache_tb.sv
